// ==== Bender.yml ====
package:
  name: spart_loader

sources:
  # packages first, then the RTL from the leaves up
  - rtl/spart_pkg.sv
  - rtl/loader_pkg.sv
  - rtl/spart_rx.sv
  - rtl/spart_tx.sv
  - rtl/spart_core.sv
  - rtl/loader_driver.sv
  - rtl/loader_mem.sv
  - rtl/spart_loader_top.sv
  - target: test
    files:
      - tb/spart_loader_sva.sv
      - tb/tb_spart_loader.sv

// ==== rtl/loader_driver.sv ====
`timescale 1ns/1ps

module loader_driver
   import spart_pkg::*;
   import loader_pkg::*;
#(
   parameter logic [15:0] BAUD_DIV_BASE = 16'h0516
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [1:0]  br_cfg_i,
   // SPART register bus
   output logic [1:0]  io_addr_o,
   output logic        io_rw_o,
   output spart_byte_t io_wdata_o,
   input  spart_byte_t io_rdata_i,
   input  logic        rda_i,
   input  logic        tbr_i,
   // data memory port
   output logic        mem_en_o,
   output logic        mem_we_o,
   output mem_addr_t   mem_addr_o,
   output mem_word_t   mem_wdata_o,
   input  mem_word_t   mem_rdata_i
);

   localparam int         AW        = $bits(mem_addr_t);
   localparam int         DIGITS    = FRAME_BYTES - 1;
   localparam logic [3:0] LAST_BYTE = 4'(FRAME_BYTES - 1);

   loader_state_t state_q;
   loader_state_t state_d;
   logic [1:0]    prev_br_cfg_q;
   logic [15:0]   baud_div;
   spart_byte_t   digit_q [DIGITS];
   spart_byte_t   cmd_q;
   logic [3:0]    frame_cnt_q;
   mem_word_t     frame_word;
   mem_addr_t     start_addr_q;
   mem_addr_t     stop_addr_q;
   // one extra bit so the loop ends even when stop is the top address
   logic [AW:0]   addr_cnt_q;
   logic [3:0]    trans_cnt_q;
   mem_word_t     out_buf_q;
   logic [2:0]    byte_sel;
   logic [3:0]    echo_idx;
   spart_byte_t   echo_byte;

   // FSM strobes
   logic ld_data;
   logic clr_cmd;
   logic start_en;
   logic stop_en;
   logic prev_br_en;
   logic ld_addr_cnt;
   logic addr_cnt_en;
   logic clr_trans_cnt;
   logic trans_cnt_en;
   logic ld_out_buf;

   // each br_cfg step halves the divisor
   assign baud_div = BAUD_DIV_BASE >> br_cfg_i;

   ////////////////////////////////////////////////////////////
   // frame capture
   ////////////////////////////////////////////////////////////

   // position of the next byte within the nine byte frame
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         frame_cnt_q <= '0;
      else if (ld_data)
         frame_cnt_q <= (frame_cnt_q == LAST_BYTE) ? 4'd0 : frame_cnt_q + 4'd1;
   end

   // digits kept as values and not as ascii
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < DIGITS; i++)
      begin
         if (ld_data && frame_cnt_q == 4'(i))
            digit_q[i] <= io_rdata_i - ASCII_ZERO;
      end
   end

   // command lives until the IDLE cycle that executes it
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         cmd_q <= '0;
      else if (clr_cmd)
         cmd_q <= '0;
      else if (ld_data && frame_cnt_q == LAST_BYTE)
         cmd_q <= io_rdata_i;
   end

   // first digit is the most significant byte
   always_comb
   begin
      for (int i = 0; i < DIGITS; i++)
         frame_word[8*(DIGITS-1-i) +: 8] = digit_q[i];
   end

   // counter already points past the byte being echoed
   assign echo_idx  = (frame_cnt_q == 4'd0) ? LAST_BYTE : frame_cnt_q - 4'd1;
   assign echo_byte = (echo_idx == LAST_BYTE) ? cmd_q : digit_q[echo_idx[2:0]] + ASCII_ZERO;

   ////////////////////////////////////////////////////////////
   // address range and dump datapath
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         start_addr_q  <= '0;
         stop_addr_q   <= '0;
         prev_br_cfg_q <= '0;
      end
      else
      begin
         if (start_en)
            start_addr_q <= frame_word[AW-1:0];
         if (stop_en)
            stop_addr_q <= frame_word[AW-1:0];
         // remember the rate just programmed
         if (prev_br_en)
            prev_br_cfg_q <= br_cfg_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         addr_cnt_q  <= '0;
         trans_cnt_q <= '0;
      end
      else
      begin
         if (ld_addr_cnt)
            addr_cnt_q <= {1'b0, start_addr_q};
         else if (addr_cnt_en)
            addr_cnt_q <= addr_cnt_q + 1'b1;
         if (clr_trans_cnt)
            trans_cnt_q <= '0;
         else if (trans_cnt_en)
            trans_cnt_q <= trans_cnt_q + 4'd1;
      end
   end

   // read data is valid in DUMP_LOAD
   always_ff @(posedge clk)
   begin
      if (ld_out_buf)
         out_buf_q <= mem_rdata_i;
   end

   // highest byte goes out first
   assign byte_sel = 3'd7 - trans_cnt_q[2:0];

   ////////////////////////////////////////////////////////////
   // command FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state_q <= BAUD_LOW;
      else
         state_q <= state_d;
   end

   always_comb
   begin
      state_d       = state_q;
      // bus rests on a status read
      io_addr_o     = SPART_ADDR_STATUS;
      io_rw_o       = 1'b1;
      io_wdata_o    = '0;
      mem_en_o      = 1'b0;
      mem_we_o      = 1'b0;
      mem_addr_o    = addr_cnt_q[AW-1:0];
      mem_wdata_o   = frame_word;
      ld_data       = 1'b0;
      clr_cmd       = 1'b0;
      start_en      = 1'b0;
      stop_en       = 1'b0;
      prev_br_en    = 1'b0;
      ld_addr_cnt   = 1'b0;
      addr_cnt_en   = 1'b0;
      clr_trans_cnt = 1'b0;
      trans_cnt_en  = 1'b0;
      ld_out_buf    = 1'b0;
      case (state_q)
         IDLE:
         begin
            if (br_cfg_i != prev_br_cfg_q)
               state_d = BAUD_LOW;
            else if (cmd_q != '0)
            begin
               // pending command runs before the next byte is taken
               clr_cmd = 1'b1;
               case (cmd_q)
                  CMD_START: start_en = 1'b1;
                  CMD_STOP:  stop_en = 1'b1;
                  CMD_WRITE:
                  begin
                     mem_en_o   = 1'b1;
                     mem_we_o   = 1'b1;
                     mem_addr_o = start_addr_q;
                  end
                  CMD_DUMP:
                  begin
                     ld_addr_cnt = 1'b1;
                     state_d     = DUMP_REQ;
                  end
                  default: clr_cmd = 1'b1;
               endcase
            end
            else if (rda_i)
            begin
               io_addr_o = SPART_ADDR_RXTX;
               ld_data   = 1'b1;
               state_d   = ECHO;
            end
         end
         ECHO:
         begin
            // a running transmission holds us here
            if (tbr_i)
            begin
               io_addr_o  = SPART_ADDR_RXTX;
               io_rw_o    = 1'b0;
               io_wdata_o = echo_byte;
               state_d    = IDLE;
            end
         end
         BAUD_LOW:
         begin
            io_addr_o  = SPART_ADDR_DIV_LO;
            io_rw_o    = 1'b0;
            io_wdata_o = baud_div[7:0];
            state_d    = BAUD_HIGH;
         end
         BAUD_HIGH:
         begin
            io_addr_o  = SPART_ADDR_DIV_HI;
            io_rw_o    = 1'b0;
            io_wdata_o = baud_div[15:8];
            prev_br_en = 1'b1;
            state_d    = IDLE;
         end
         DUMP_REQ:
         begin
            // loop ends once the counter passes the stop address
            if (addr_cnt_q <= {1'b0, stop_addr_q})
            begin
               mem_en_o    = 1'b1;
               addr_cnt_en = 1'b1;
               state_d     = DUMP_LOAD;
            end
            else
               state_d = IDLE;
         end
         DUMP_LOAD:
         begin
            ld_out_buf    = 1'b1;
            clr_trans_cnt = 1'b1;
            state_d       = DUMP_SEND;
         end
         DUMP_SEND:
         begin
            if (trans_cnt_q == 4'd8)
               state_d = DUMP_REQ;
            else if (tbr_i)
            begin
               io_addr_o    = SPART_ADDR_RXTX;
               io_rw_o      = 1'b0;
               io_wdata_o   = out_buf_q[{byte_sel, 3'b000} +: 8];
               trans_cnt_en = 1'b1;
            end
         end
         default:
            state_d = IDLE;
      endcase
   end

endmodule

// ==== rtl/loader_mem.sv ====
`timescale 1ns/1ps

module loader_mem
   import loader_pkg::*;
#(
   parameter int MEM_DEPTH = 16384
) (
   input  logic      clk,
   input  logic      mem_en_i,
   input  logic      mem_we_i,
   input  mem_addr_t mem_addr_i,
   input  mem_word_t mem_wdata_i,
   output mem_word_t mem_rdata_o
);

   localparam int AW = $clog2(MEM_DEPTH);

   mem_word_t   mem_q [MEM_DEPTH];
   logic [AW-1:0] mem_idx;

   // upper address bits are ignored on a smaller array
   assign mem_idx = mem_addr_i[AW-1:0];

   // one cycle read latency
   always_ff @(posedge clk)
   begin
      if (mem_en_i && mem_we_i)
         mem_q[mem_idx] <= mem_wdata_i;
      else if (mem_en_i)
         mem_rdata_o <= mem_q[mem_idx];
   end

endmodule

// ==== rtl/loader_pkg.sv ====
package loader_pkg;

   ////////////////////////////////////////////////////////////
   // data memory geometry
   ////////////////////////////////////////////////////////////

   // word address into the data memory
   typedef logic [13:0] mem_addr_t;
   // one memory word built from eight frame digits
   typedef logic [63:0] mem_word_t;

   ////////////////////////////////////////////////////////////
   // driver FSM
   ////////////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      IDLE,
      ECHO,
      BAUD_LOW,
      BAUD_HIGH,
      DUMP_REQ,
      DUMP_LOAD,
      DUMP_SEND
   } loader_state_t;

   ////////////////////////////////////////////////////////////
   // frame format and command bytes
   ////////////////////////////////////////////////////////////

   // 'a' loads the start address
   localparam logic [7:0] CMD_START = 8'h61;
   // 'e' loads the stop address
   localparam logic [7:0] CMD_STOP  = 8'h65;
   // 'w' writes the word at the start address
   localparam logic [7:0] CMD_WRITE = 8'h77;
   // 'd' dumps start to stop inclusive
   localparam logic [7:0] CMD_DUMP  = 8'h64;

   // digits arrive as ascii and are stored as values
   localparam logic [7:0] ASCII_ZERO = 8'h30;

   // eight digits then one command byte
   localparam int FRAME_BYTES = 9;

endpackage

// ==== rtl/spart_core.sv ====
`timescale 1ns/1ps

module spart_core
   import spart_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [1:0]  io_addr_i,
   input  logic        io_rw_i,
   input  spart_byte_t io_wdata_i,
   output spart_byte_t io_rdata_o,
   output logic        rda_o,
   output logic        tbr_o,
   input  logic        rx_i,
   output logic        tx_o
);

   logic [15:0] divisor_q;
   logic [15:0] div_cnt_q;
   logic        tick;
   logic        div_wr;
   logic        rx_done;
   spart_byte_t rx_byte;
   spart_byte_t rx_buf_q;
   logic        tx_start;
   logic        tx_busy;
   logic        rx_rd;

   ////////////////////////////////////////////////////////////
   // bus decode
   ////////////////////////////////////////////////////////////

   assign div_wr = !io_rw_i &&
                   (io_addr_i == SPART_ADDR_DIV_LO || io_addr_i == SPART_ADDR_DIV_HI);
   assign rx_rd  = io_rw_i && (io_addr_i == SPART_ADDR_RXTX);
   // a transmit write only starts when the transmitter is free
   assign tx_start = !io_rw_i && (io_addr_i == SPART_ADDR_RXTX) && !tx_busy;

   always_comb
   begin
      case (io_addr_i)
         SPART_ADDR_RXTX:   io_rdata_o = rx_buf_q;
         SPART_ADDR_STATUS: io_rdata_o = {6'b0, tbr_o, rda_o};
         SPART_ADDR_DIV_LO: io_rdata_o = divisor_q[7:0];
         default:           io_rdata_o = divisor_q[15:8];
      endcase
   end

   ////////////////////////////////////////////////////////////
   // divisor and baud tick
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         divisor_q <= '0;
      else if (!io_rw_i && io_addr_i == SPART_ADDR_DIV_LO)
         divisor_q[7:0] <= io_wdata_i;
      else if (!io_rw_i && io_addr_i == SPART_ADDR_DIV_HI)
         divisor_q[15:8] <= io_wdata_i;
   end

   // one tick every divisor cycles
   // restarted on every divisor write so a new rate applies at once
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         div_cnt_q <= '0;
      else if (div_wr)
         div_cnt_q <= '0;
      else if (tick)
         div_cnt_q <= divisor_q - 16'd1;
      else
         div_cnt_q <= div_cnt_q - 16'd1;
   end

   assign tick = (div_cnt_q == '0);

   ////////////////////////////////////////////////////////////
   // receive buffer and status
   ////////////////////////////////////////////////////////////

   // new byte wins over a read in the same cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rda_o <= 1'b0;
      else if (rx_done)
         rda_o <= 1'b1;
      else if (rx_rd)
         rda_o <= 1'b0;
   end

   // unread byte is simply overwritten
   always_ff @(posedge clk)
   begin
      if (rx_done)
         rx_buf_q <= rx_byte;
   end

   assign tbr_o = !tx_busy;

   spart_rx i_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .tick_i    (tick),
      .rx_i      (rx_i),
      .rx_done_o (rx_done),
      .rx_byte_o (rx_byte)
   );

   spart_tx i_tx (
      .clk        (clk),
      .rst_n      (rst_n),
      .tick_i     (tick),
      .tx_start_i (tx_start),
      .tx_byte_i  (io_wdata_i),
      .tx_o       (tx_o),
      .tx_busy_o  (tx_busy)
   );

endmodule

// ==== rtl/spart_loader_top.sv ====
`timescale 1ns/1ps

module spart_loader_top
   import loader_pkg::*;
#(
   parameter logic [15:0] BAUD_DIV_BASE = 16'h0516,
   parameter int          MEM_DEPTH     = 16384
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [1:0] br_cfg_i,
   input  logic       rx_i,
   output logic       tx_o
);

   // SPART register bus
   logic [1:0] io_addr;
   logic       io_rw;
   logic [7:0] io_wdata;
   logic [7:0] io_rdata;
   logic       rda;
   logic       tbr;

   // memory port
   logic       mem_en;
   logic       mem_we;
   mem_addr_t  mem_addr;
   mem_word_t  mem_wdata;
   mem_word_t  mem_rdata;

   spart_core i_spart (
      .clk        (clk),
      .rst_n      (rst_n),
      .io_addr_i  (io_addr),
      .io_rw_i    (io_rw),
      .io_wdata_i (io_wdata),
      .io_rdata_o (io_rdata),
      .rda_o      (rda),
      .tbr_o      (tbr),
      .rx_i       (rx_i),
      .tx_o       (tx_o)
   );

   loader_driver #(
      .BAUD_DIV_BASE (BAUD_DIV_BASE)
   ) i_driver (
      .clk         (clk),
      .rst_n       (rst_n),
      .br_cfg_i    (br_cfg_i),
      .io_addr_o   (io_addr),
      .io_rw_o     (io_rw),
      .io_wdata_o  (io_wdata),
      .io_rdata_i  (io_rdata),
      .rda_i       (rda),
      .tbr_i       (tbr),
      .mem_en_o    (mem_en),
      .mem_we_o    (mem_we),
      .mem_addr_o  (mem_addr),
      .mem_wdata_o (mem_wdata),
      .mem_rdata_i (mem_rdata)
   );

   loader_mem #(
      .MEM_DEPTH (MEM_DEPTH)
   ) i_mem (
      .clk         (clk),
      .mem_en_i    (mem_en),
      .mem_we_i    (mem_we),
      .mem_addr_i  (mem_addr),
      .mem_wdata_i (mem_wdata),
      .mem_rdata_o (mem_rdata)
   );

endmodule

// ==== rtl/spart_pkg.sv ====
package spart_pkg;

   ////////////////////////////////////////////////////////////
   // register map seen on the driver bus
   ////////////////////////////////////////////////////////////

   // receive buffer on read and transmit data on write
   localparam logic [1:0] SPART_ADDR_RXTX   = 2'd0;
   // status register with tbr in bit 1 and rda in bit 0
   localparam logic [1:0] SPART_ADDR_STATUS = 2'd1;
   // divisor bytes written low byte first
   localparam logic [1:0] SPART_ADDR_DIV_LO = 2'd2;
   localparam logic [1:0] SPART_ADDR_DIV_HI = 2'd3;

   ////////////////////////////////////////////////////////////
   // serial framing
   ////////////////////////////////////////////////////////////

   // baud ticks per serial bit
   localparam int OVERSAMPLE = 16;

   // one character on the line
   typedef logic [7:0] spart_byte_t;

endpackage

// ==== rtl/spart_rx.sv ====
`timescale 1ns/1ps

module spart_rx
   import spart_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        tick_i,
   input  logic        rx_i,
   output logic        rx_done_o,
   output spart_byte_t rx_byte_o
);

   // middle of the start bit and end of a full bit
   localparam logic [3:0] MID_TICK  = 4'(OVERSAMPLE / 2 - 1);
   localparam logic [3:0] LAST_TICK = 4'(OVERSAMPLE - 1);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t   state_q;
   logic [1:0]  rx_sync_q;
   logic        rx_s;
   logic [3:0]  tick_cnt_q;
   logic [2:0]  bit_cnt_q;
   logic        bit_end;
   spart_byte_t shift_q;

   // two flop synchronizer on the asynchronous line
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rx_sync_q <= 2'b11;
      else
         rx_sync_q <= {rx_sync_q[0], rx_i};
   end

   assign rx_s = rx_sync_q[1];

   // after the start bit centre every 16 ticks land mid bit
   assign bit_end = tick_i && (tick_cnt_q == LAST_TICK);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q    <= RX_IDLE;
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
         rx_done_o  <= 1'b0;
      end
      else
      begin
         rx_done_o <= 1'b0;
         if (tick_i)
            tick_cnt_q <= tick_cnt_q + 4'd1;
         case (state_q)
            RX_IDLE:
            begin
               // falling edge marks a start bit
               tick_cnt_q <= '0;
               if (!rx_s)
                  state_q <= RX_START;
            end
            RX_START:
            begin
               if (tick_i && tick_cnt_q == MID_TICK)
               begin
                  tick_cnt_q <= '0;
                  bit_cnt_q  <= '0;
                  // a line back high here was only a glitch
                  state_q    <= rx_s ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA:
            begin
               if (bit_end)
               begin
                  bit_cnt_q <= bit_cnt_q + 3'd1;
                  if (bit_cnt_q == 3'd7)
                     state_q <= RX_STOP;
               end
            end
            RX_STOP:
            begin
               // bad stop bit drops the whole character
               if (bit_end)
               begin
                  rx_done_o <= rx_s;
                  state_q   <= RX_IDLE;
               end
            end
            default:
               state_q <= RX_IDLE;
         endcase
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk)
   begin
      if (state_q == RX_DATA && bit_end)
         shift_q <= {rx_s, shift_q[7:1]};
   end

   assign rx_byte_o = shift_q;

endmodule

// ==== rtl/spart_tx.sv ====
`timescale 1ns/1ps

module spart_tx
   import spart_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        tick_i,
   input  logic        tx_start_i,
   input  spart_byte_t tx_byte_i,
   output logic        tx_o,
   output logic        tx_busy_o
);

   // start bit, eight data bits and stop bit
   localparam logic [3:0] FRAME_BITS = 4'd10;
   localparam logic [3:0] LAST_TICK  = 4'(OVERSAMPLE - 1);

   logic       busy_q;
   logic [3:0] tick_cnt_q;
   logic [3:0] bit_cnt_q;
   logic [9:0] shift_q;
   logic       bit_end;
   logic       load;

   assign load    = tx_start_i && !busy_q;
   assign bit_end = busy_q && tick_i && (tick_cnt_q == LAST_TICK);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy_q     <= 1'b0;
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
      end
      else if (load)
      begin
         busy_q     <= 1'b1;
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
      end
      else if (busy_q && tick_i)
      begin
         tick_cnt_q <= tick_cnt_q + 4'd1;
         if (bit_end)
         begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
            // busy drops once the stop bit has run its 16 ticks
            if (bit_cnt_q == FRAME_BITS - 4'd1)
               busy_q <= 1'b0;
         end
      end
   end

   // frame is shifted out from bit 0 with ones filling behind
   always_ff @(posedge clk)
   begin
      if (load)
         shift_q <= {1'b1, tx_byte_i, 1'b0};
      else if (bit_end)
         shift_q <= {1'b1, shift_q[9:1]};
   end

   // line idles high between characters
   assign tx_o      = busy_q ? shift_q[0] : 1'b1;
   assign tx_busy_o = busy_q;

endmodule

// ==== sources.f ====
rtl/spart_pkg.sv
rtl/loader_pkg.sv
rtl/spart_rx.sv
rtl/spart_tx.sv
rtl/spart_core.sv
rtl/loader_driver.sv
rtl/loader_mem.sv
rtl/spart_loader_top.sv
tb/spart_loader_sva.sv
tb/tb_spart_loader.sv

// ==== tb/spart_loader_sva.sv ====
`timescale 1ns/1ps

module spart_loader_sva
   import spart_pkg::*;
(
   input logic       clk,
   input logic       rst_n,
   input logic [1:0] io_addr_i,
   input logic       io_rw_i,
   input logic       tbr_i,
   input logic       mem_en_i,
   input logic       mem_we_i
);

   // running count of failed checks, read by the testbench
   int fail_cnt = 0;

   logic tx_wr;
   logic div_lo_wr;
   logic div_hi_wr;

   assign tx_wr     = !io_rw_i && (io_addr_i == SPART_ADDR_RXTX);
   assign div_lo_wr = !io_rw_i && (io_addr_i == SPART_ADDR_DIV_LO);
   assign div_hi_wr = !io_rw_i && (io_addr_i == SPART_ADDR_DIV_HI);

   ////////////////////////////////////////////////////////////
   // SPART bus
   ////////////////////////////////////////////////////////////

   // transmit register only written while the transmitter is free
   tx_wr_needs_tbr: assert property (@(posedge clk) disable iff (!rst_n)
      tx_wr |-> tbr_i)
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("transmit write while tbr is low");
   end

   // divisor goes out low byte then high byte on back to back cycles
   div_lo_before_hi: assert property (@(posedge clk) disable iff (!rst_n)
      div_hi_wr |-> $past(div_lo_wr))
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("divisor high byte written without the low byte just before");
   end

   ////////////////////////////////////////////////////////////
   // memory port
   ////////////////////////////////////////////////////////////

   // a write strobe is only meaningful with the enable
   we_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
      mem_we_i |-> mem_en_i)
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("memory write enable without memory enable");
   end

endmodule

// ==== tb/spart_loader_trace.txt ====
// columns: br_cfg, byte sent on rx, count of bytes back on tx, bytes back (all hex)
// frame 'a' start address 1 at br_cfg 0
00 30 01 30
00 30 01 30
00 30 01 30
00 30 01 30
00 30 01 30
00 30 01 30
00 30 01 30
00 31 01 31
00 61 01 61
// frame 'w' word 0102030405060708
00 31 01 31
00 32 01 32
00 33 01 33
00 34 01 34
00 35 01 35
00 36 01 36
00 37 01 37
00 38 01 38
00 77 01 77
// frame 'a' start address 2 at br_cfg 1
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 32 01 32
01 61 01 61
// frame 'w' word 0807060504030201
01 38 01 38
01 37 01 37
01 36 01 36
01 35 01 35
01 34 01 34
01 33 01 33
01 32 01 32
01 31 01 31
01 77 01 77
// frame 'a' start address 3 at br_cfg 2
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 33 01 33
02 61 01 61
// frame 'w' word 0204060800010305
02 32 01 32
02 34 01 34
02 36 01 36
02 38 01 38
02 30 01 30
02 31 01 31
02 33 01 33
02 35 01 35
02 77 01 77
// frame 'e' stop address 3 at br_cfg 3
03 30 01 30
03 30 01 30
03 30 01 30
03 30 01 30
03 30 01 30
03 30 01 30
03 30 01 30
03 33 01 33
03 65 01 65
// unknown command 'x' is only echoed
00 39 01 39
00 39 01 39
00 39 01 39
00 39 01 39
00 39 01 39
00 39 01 39
00 39 01 39
00 39 01 39
00 78 01 78
// frame 'd' over address 3 only
03 30 01 30
03 30 01 30
03 30 01 30
03 30 01 30
03 30 01 30
03 30 01 30
03 30 01 30
03 30 01 30
03 64 09 64 02 04 06 08 00 01 03 05
// frame 'a' start address 1
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 31 01 31
01 61 01 61
// frame 'd' over addresses 1 to 3
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 30 01 30
01 64 19 64 01 02 03 04 05 06 07 08 08 07 06 05 04 03 02 01 02 04 06 08 00 01 03 05
// frame 'e' stop address 0, below the start
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 65 01 65
// frame 'd' with an empty range returns the echo only
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 30 01 30
02 64 01 64
// end marker
ff

// ==== tb/tb_spart_loader.sv ====
`timescale 1ns/1ps

module tb_spart_loader;

   localparam logic [15:0] BAUD_BASE     = 16'd16;
   localparam int          MEM_DEPTH     = 64;
   localparam int          TICKS_PER_BIT = 16;
   // bit period at br_cfg 0, the slowest setting
   localparam int          SLOW_BIT      = TICKS_PER_BIT * 16;
   localparam int          FRAME_LEN     = 9;
   localparam int          MAX_GAP       = 3;
   localparam int          TRACE_WORDS   = 1024;
   localparam logic [7:0]  END_MARK      = 8'hff;
   localparam int          CFG_SETTLE    = 8;
   localparam string       TRACE_FILE    = "tb/spart_loader_trace.txt";

   logic       clk;
   logic       rst_n;
   logic [1:0] br_cfg;
   logic       rx;
   logic       tx;

   // flat trace words: cfg, byte out, count, bytes back
   logic [7:0] trace_mem [TRACE_WORDS];
   int         trace_len;
   int         cycle_cnt   = 0;
   int         cycle_limit = 0;
   integer     seed;

   spart_loader_top #(
      .BAUD_DIV_BASE (BAUD_BASE),
      .MEM_DEPTH     (MEM_DEPTH)
   ) i_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .br_cfg_i (br_cfg),
      .rx_i     (rx),
      .tx_o     (tx)
   );

   bind loader_driver spart_loader_sva i_sva (
      .clk       (clk),
      .rst_n     (rst_n),
      .io_addr_i (io_addr_o),
      .io_rw_i   (io_rw_o),
      .tbr_i     (tbr_i),
      .mem_en_i  (mem_en_o),
      .mem_we_i  (mem_we_o)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // host side of the serial line
   ////////////////////////////////////////////////////////////

   // 16 ticks per bit, the divisor halves with each br_cfg step
   function automatic int bit_cycles(input logic [1:0] cfg);
      return TICKS_PER_BIT * int'(BAUD_BASE >> cfg);
   endfunction

   task automatic send_byte(input logic [7:0] data, input int period);
      logic [9:0] frame;
      int         i;
      // start bit, data lsb first, stop bit
      frame = {1'b1, data, 1'b0};
      for (i = 0; i < 10; i++)
      begin
         @(posedge clk);
         rx <= frame[i];
         repeat (period - 1)
            @(posedge clk);
      end
   endtask

   task automatic receive_byte(input logic [7:0] expected, input int period);
      logic [7:0] got;
      int         b;
      // hunt for the start edge
      @(negedge clk);
      while (tx !== 1'b0)
         @(negedge clk);
      repeat (period / 2)
         @(negedge clk);
      assert (tx === 1'b0)
      else
      begin
         $display("start bit on tx_o ended before mid bit at %0t", $time);
         $display("TESTS FAILED");
         $fatal(1, "framing error on the start bit");
      end
      // one sample per bit, near the centre
      for (b = 0; b < 8; b++)
      begin
         repeat (period)
            @(negedge clk);
         got[b] = tx;
      end
      repeat (period)
         @(negedge clk);
      assert (tx === 1'b1)
      else
      begin
         $display("stop bit on tx_o was not high at %0t", $time);
         $display("TESTS FAILED");
         $fatal(1, "framing error on the stop bit");
      end
      assert (got === expected)
      else
      begin
         $display("ERROR: time %0t tx_o expected %02h received %02h", $time, expected, got);
         $display("TESTS FAILED");
         $fatal(1, "wrong byte on the serial line");
      end
   endtask

   task automatic expect_bytes(input int first, input int count, input int period);
      int k;
      for (k = 0; k < count; k++)
         receive_byte(trace_mem[first + k], period);
   endtask

   // line must stay idle, catches extra or duplicated bytes
   task automatic check_quiet(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk);
         assert (tx === 1'b1)
         else
         begin
            $display("tx_o started a byte at %0t when none was expected", $time);
            $display("TESTS FAILED");
            $fatal(1, "unexpected transmission");
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // trace and run limit
   ////////////////////////////////////////////////////////////

   task automatic load_trace();
      int idx;
      int n;
      idx = 0;
      $readmemh(TRACE_FILE, trace_mem);
      // reset, rate changes and the final idle check
      cycle_limit = 100 * SLOW_BIT;
      while (idx < TRACE_WORDS && !$isunknown(trace_mem[idx]) && trace_mem[idx] != END_MARK)
      begin
         n = int'(trace_mem[idx + 2]);
         // every record costed at the slowest bit rate
         cycle_limit += (10 + 10 * n + MAX_GAP + 2) * SLOW_BIT;
         idx += 3 + n;
      end
      trace_len = idx;
      assert (trace_len > 0)
      else
      begin
         $display("the trace file could not be read or holds no records");
         $display("TESTS FAILED");
         $fatal(1, "no stimulus");
      end
   endtask

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
      begin
         $display("no response from the DUT within %0d cycles", cycle_limit);
         $display("TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   // bound checks count their failures, stop at the first one
   always @(negedge clk)
   begin
      assert (i_dut.i_driver.i_sva.fail_cnt == 0)
      else
      begin
         $display("a bound assertion on the driver ports failed at %0t", $time);
         $display("TESTS FAILED");
         $fatal(1, "assertion failure");
      end
   end

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      int         idx;
      int         n;
      int         period;
      int         gap;
      int         sent;
      logic [1:0] cfg;
      rst_n  = 1'b0;
      rx     = 1'b1;
      br_cfg = 2'd0;
      seed   = 32'hc77f_ad36;
      idx    = 0;
      sent   = 0;
      period = bit_cycles(2'd0);
      load_trace();
      repeat (2)
         @(posedge clk);
      rst_n <= 1'b1;
      repeat (CFG_SETTLE)
         @(posedge clk);
      while (idx < trace_len)
      begin
         cfg = trace_mem[idx][1:0];
         // new rate is picked up by the driver from IDLE
         if (cfg != br_cfg)
         begin
            @(posedge clk);
            br_cfg <= cfg;
            repeat (CFG_SETTLE)
               @(posedge clk);
         end
         period = bit_cycles(cfg);
         n      = int'(trace_mem[idx + 2]);
         // echo can start before our stop bit ends
         fork
            send_byte(trace_mem[idx + 1], period);
            expect_bytes(idx + 3, n, period);
         join
         sent++;
         idx += 3 + n;
         // random idle time between frames
         if (sent % FRAME_LEN == 0)
         begin
            gap = $random(seed) & 32'h3;
            check_quiet(gap * period);
         end
      end
      // nothing may follow the last expected byte
      check_quiet(20 * period);
      if (i_dut.i_driver.i_sva.fail_cnt != 0)
      begin
         $display("bound assertions on the driver ports failed");
         $display("TESTS FAILED");
         $fatal(1, "assertion failure at end of run");
      end
      else
      begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule
